/* lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width.
`define LSU_ADDR_BITS 11

// memory depth in bytes.
`define LSU_MEM_BYTES 2048

// data word width, four byte lanes.
`define LSU_WORD_BITS 32

// lanes are numbered 3 down to 0, lane 3 sits at the lowest address.
// a word is therefore stored big-endian.

`endif

/* lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_ADDR_BITS-1:0] byte_addr_t;
    typedef logic [`LSU_WORD_BITS-1:0] word_t;
    typedef logic [7:0]                mem_byte_t;
    typedef logic [3:0]                frame_mask_t; // bit 3 is base + 0.

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LBU = 3'd1,
        OP_LH  = 3'd2,
        OP_LHU = 3'd3,
        OP_LW  = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_t;

    typedef enum logic [1:0] {E_IDLE, E_XFER, E_FINISH} engine_state_t;
    typedef enum logic [1:0] {H_IDLE, H_BUSY, H_ACK} hs_state_t;

    typedef struct packed {
        mem_op_t    op;
        byte_addr_t addr;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        byte_addr_t  base;       // word aligned.
        frame_mask_t mask;
        logic        write;
        mem_op_t     op;
        word_t       lane_data;  // store bytes already in their lanes.
        logic        misaligned;
    } mem_access_t;

    typedef struct packed {
        word_t rdata;
        logic  err;
    } mem_rsp_t;

endpackage

/* lsu_decode.sv */
`include "lsu_cfg.svh"

module lsu_decode (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 start,
    input  lsu_pkg::mem_req_t    held_req,
    output lsu_pkg::mem_access_t access,
    output logic                 access_valid
);
    import lsu_pkg::*;

    logic [1:0]  offset;
    frame_mask_t mask;
    logic        misaligned;
    logic        is_store;
    word_t       placed;
    word_t       lane_sel;

    assign offset   = held_req.addr[1:0];
    assign is_store = held_req.op inside {OP_SB, OP_SH, OP_SW};

    // frame mask and alignment check.
    always_comb begin
        mask       = 4'b0000;
        misaligned = 1'b0;
        case (held_req.op)
            OP_LB, OP_LBU, OP_SB: begin
                mask = 4'b1000 >> offset; // offset 0 is lane 3.
            end
            OP_LH, OP_LHU, OP_SH: begin
                if (offset[0]) begin
                    misaligned = 1'b1;
                end else begin
                    mask = offset[1] ? 4'b0011 : 4'b1100;
                end
            end
            default: begin
                if (offset != 2'd0) begin // words only at offset 0.
                    misaligned = 1'b1;
                end else begin
                    mask = 4'b1111;
                end
            end
        endcase
    end

    // replicate store data over all lanes, the mask keeps the right ones.
    always_comb begin
        case (held_req.op)
            OP_SB:   placed = {4{held_req.wdata[7:0]}};
            OP_SH:   placed = {2{held_req.wdata[15:0]}};
            OP_SW:   placed = held_req.wdata;
            default: placed = '0;
        endcase
    end

    assign lane_sel = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            access_valid <= 1'b0;
        end else begin
            access_valid <= start; // one cycle behind start.
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            access.base       <= {held_req.addr[`LSU_ADDR_BITS-1:2], 2'b00};
            access.mask       <= mask;
            access.write      <= is_store;
            access.op         <= held_req.op;
            access.lane_data  <= placed & lane_sel;
            access.misaligned <= misaligned;
        end
    end

endmodule

/* byte_mem_engine.sv */
`include "lsu_cfg.svh"

module byte_mem_engine (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  lsu_pkg::mem_access_t access,
    input  logic                 access_valid,
    output logic                 done,
    output lsu_pkg::word_t       rd_lanes,
    output logic                 err,
    output logic                 busy
);
    import lsu_pkg::*;

    mem_byte_t mem [`LSU_MEM_BYTES];

    engine_state_t state;
    frame_mask_t   pending;      // lanes still to move.
    frame_mask_t   pending_next;
    logic [1:0]    lane;
    byte_addr_t    xfer_addr;
    logic          accept;

    byte_addr_t    base_q;
    logic          write_q;
    word_t         wr_lanes_q;
    logic          misaligned_q;

    assign accept = (state == E_IDLE) && access_valid;

    // highest pending lane goes first, which walks the mask from bit 3 down.
    always_comb begin
        if (pending[3]) begin
            lane = 2'd3;
        end else if (pending[2]) begin
            lane = 2'd2;
        end else if (pending[1]) begin
            lane = 2'd1;
        end else begin
            lane = 2'd0;
        end
    end

    assign pending_next = pending & ~(4'b0001 << lane);

    // lane 3 is offset 0, so the offset is the inverted lane index.
    assign xfer_addr = {base_q[`LSU_ADDR_BITS-1:2], ~lane};

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= E_IDLE;
            pending <= 4'b0000;
        end else begin
            case (state)
                E_IDLE: begin
                    if (access_valid) begin
                        pending <= access.mask;
                        // misaligned requests arrive with an empty mask.
                        if (access.mask == 4'b0000) begin
                            state <= E_FINISH;
                        end else begin
                            state <= E_XFER;
                        end
                    end
                end
                E_XFER: begin
                    pending <= pending_next;
                    if (pending_next == 4'b0000) begin
                        state <= E_FINISH;
                    end
                end
                E_FINISH: begin
                    state <= E_IDLE;
                end
                default: begin
                    state <= E_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            base_q       <= access.base;
            write_q      <= access.write;
            wr_lanes_q   <= access.lane_data;
            misaligned_q <= access.misaligned;
            rd_lanes     <= '0; // unselected lanes read as zero.
        end else if (state == E_XFER && !write_q) begin
            rd_lanes[{lane, 3'b000} +: 8] <= mem[xfer_addr];
        end
    end

    // one byte per cycle.
    always_ff @(posedge CLK) begin
        if (state == E_XFER) begin
            if (write_q) begin
                mem[xfer_addr] <= wr_lanes_q[{lane, 3'b000} +: 8];
            end
        end
    end

    assign done = (state == E_FINISH);
    assign err  = misaligned_q; // sampled together with done.
    assign busy = access_valid || (state != E_IDLE);

endmodule

/* lsu_response.sv */
`include "lsu_cfg.svh"

module lsu_response (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              req,
    input  lsu_pkg::mem_req_t request,
    output logic              ack,
    output lsu_pkg::mem_rsp_t response,
    output logic              start,
    output lsu_pkg::mem_req_t held_req,
    input  logic              done,
    input  lsu_pkg::word_t    rd_lanes,
    input  logic              err
);
    import lsu_pkg::*;

    hs_state_t   state;
    mem_byte_t   byte_fold;
    logic [15:0] half_fold;
    word_t       rdata;

    // lanes outside the mask are zero, so an OR fold right-justifies the data.
    assign byte_fold = rd_lanes[31:24] | rd_lanes[23:16] | rd_lanes[15:8] | rd_lanes[7:0];
    assign half_fold = rd_lanes[31:16] | rd_lanes[15:0];

    always_comb begin
        case (held_req.op)
            OP_LB:   rdata = {{24{byte_fold[7]}}, byte_fold};
            OP_LBU:  rdata = {24'd0, byte_fold};
            OP_LH:   rdata = {{16{half_fold[15]}}, half_fold};
            OP_LHU:  rdata = {16'd0, half_fold};
            OP_LW:   rdata = rd_lanes;
            default: rdata = '0; // stores.
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state <= H_IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                H_IDLE: begin
                    if (req) begin
                        start <= 1'b1;
                        state <= H_BUSY;
                    end
                end
                H_BUSY: begin
                    if (done) begin
                        state <= H_ACK;
                    end
                end
                H_ACK: begin
                    if (!req) begin // client let go.
                        state <= H_IDLE;
                    end
                end
                default: begin
                    state <= H_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == H_IDLE && req) begin
            held_req <= request;
        end
        if (state == H_BUSY && done) begin
            response.rdata <= rdata;
            response.err   <= err;
        end
    end

    assign ack = (state == H_ACK);

endmodule

/* lsu_top.sv */
`include "lsu_cfg.svh"

module lsu_top (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              req,
    input  lsu_pkg::mem_req_t request,
    output logic              ack,
    output lsu_pkg::mem_rsp_t response
);
    import lsu_pkg::*;

    logic        start;
    mem_req_t    held_req;
    mem_access_t access;
    logic        access_valid;
    logic        done;
    word_t       rd_lanes;
    logic        err;
    logic        busy; // engine activity, internal only.

    lsu_response i_lsu_response (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response),
        .start    (start),
        .held_req (held_req),
        .done     (done),
        .rd_lanes (rd_lanes),
        .err      (err)
    );

    lsu_decode i_lsu_decode (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .start        (start),
        .held_req     (held_req),
        .access       (access),
        .access_valid (access_valid)
    );

    byte_mem_engine i_byte_mem_engine (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .access       (access),
        .access_valid (access_valid),
        .done         (done),
        .rd_lanes     (rd_lanes),
        .err          (err),
        .busy         (busy)
    );

endmodule

/* tb_clock.sv */
module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic CLK
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD_NS / 2) CLK = ~CLK; // free running.

endmodule

/* tb_lsu.sv */
`include "lsu_cfg.svh"

module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int WORDS           = `LSU_MEM_BYTES / 4;
    localparam int MIX_OPS         = 1500;
    localparam int MISALIGN_OPS    = 40;
    localparam int ACK_LIMIT       = 32;
    localparam int WATCHDOG_CYCLES = (WORDS + MIX_OPS) * 12;

    logic     CLK;
    logic     arst_n;
    logic     req;
    mem_req_t request;
    logic     ack;
    mem_rsp_t response;

    mem_byte_t model_mem [`LSU_MEM_BYTES]; // expected memory, big-endian.

    int err_count;
    int check_count;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) i_tb_clock (.CLK(CLK));

    lsu_top i_lsu_top (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // most requests release at once, a few hold req for up to 5 cycles.
    function automatic int pick_hold();
        int r;
        r = $urandom_range(0, 15);
        if (r > 5) begin
            r = 0;
        end
        return r;
    endfunction

    function automatic word_t rand_word();
        return $urandom;
    endfunction

    // aligned address for op inside a 64 byte window.
    function automatic byte_addr_t aligned_addr(input mem_op_t op, input byte_addr_t win_base);
        logic [31:0] r;
        byte_addr_t  a;
        r = $urandom;
        a = win_base + {5'd0, r[5:0]};
        case (op)
            OP_LH, OP_LHU, OP_SH: a[0] = 1'b0;
            OP_LW, OP_SW:         a[1:0] = 2'b00;
            default:              a = a;
        endcase
        return a;
    endfunction

    function automatic mem_op_t misaligned_op();
        case ($urandom_range(0, 4))
            0:       return OP_LH;
            1:       return OP_LHU;
            2:       return OP_SH;
            3:       return OP_LW;
            default: return OP_SW;
        endcase
    endfunction

    function automatic byte_addr_t misaligned_addr(input mem_op_t op);
        logic [31:0] r;
        byte_addr_t  a;
        r = $urandom;
        a = r[`LSU_ADDR_BITS-1:0];
        if (op == OP_LW || op == OP_SW) begin
            if (a[1:0] == 2'b00) begin
                a[0] = 1'b1;
            end
        end else begin
            a[0] = 1'b1; // odd offset breaks a halfword.
        end
        return a;
    endfunction

    // expected response and latency; stores update the model.
    task automatic model_apply(input mem_op_t op, input byte_addr_t addr, input word_t wdata,
                               output word_t exp_rdata, output logic exp_err, output int exp_lat);
        mem_byte_t   b;
        logic [15:0] h;
        logic        half_op;
        logic        word_op;
        int          a;
        a         = int'(addr);
        exp_rdata = '0;
        exp_err   = 1'b0;
        half_op   = (op == OP_LH || op == OP_LHU || op == OP_SH);
        word_op   = (op == OP_LW || op == OP_SW);
        if ((half_op && addr[0]) || (word_op && addr[1:0] != 2'b00)) begin
            exp_err = 1'b1;
            exp_lat = 3;
        end else begin
            exp_lat = word_op ? 7 : (half_op ? 5 : 4);
            case (op)
                OP_LB: begin
                    b         = model_mem[a];
                    exp_rdata = {{24{b[7]}}, b};
                end
                OP_LBU: exp_rdata = {24'd0, model_mem[a]};
                OP_LH: begin
                    h         = {model_mem[a], model_mem[a + 1]};
                    exp_rdata = {{16{h[15]}}, h};
                end
                OP_LHU: exp_rdata = {16'd0, model_mem[a], model_mem[a + 1]};
                OP_LW: begin
                    exp_rdata = {model_mem[a], model_mem[a + 1],
                                 model_mem[a + 2], model_mem[a + 3]};
                end
                OP_SB: model_mem[a] = wdata[7:0];
                OP_SH: begin
                    model_mem[a]     = wdata[15:8];
                    model_mem[a + 1] = wdata[7:0];
                end
                default: begin
                    model_mem[a]     = wdata[31:24];
                    model_mem[a + 1] = wdata[23:16];
                    model_mem[a + 2] = wdata[15:8];
                    model_mem[a + 3] = wdata[7:0];
                end
            endcase
        end
    endtask

    // full four-phase cycle, called right after a falling edge.
    task automatic run_handshake(input mem_req_t rq, input int hold,
                                 output mem_rsp_t rsp, output int lat);
        int          cnt;
        logic        got;
        logic [63:0] junk;
        request = rq;
        req     = 1'b1;
        cnt     = 0;
        got     = 1'b0;
        while (!got && cnt < ACK_LIMIT) begin
            @(negedge CLK);
            cnt++;
            got = ack;
        end
        rsp = response;
        lat = cnt - 1; // first rising edge is cycle 0.
        if (!got) begin
            err_count++;
            $display("No ack from the DUT within %0d cycles at %0d ns", ACK_LIMIT, $time);
        end else begin
            repeat (hold) begin
                @(negedge CLK);
                check_eq(32'(ack), 32'd1, "ack held while req stays high");
                check_eq(response.rdata, rsp.rdata, "rdata stable while ack high");
                check_eq(32'(response.err), 32'(rsp.err), "err stable while ack high");
                check_eq(32'(i_lsu_top.start), 32'd0, "no new access while ack high");
            end
        end
        junk    = {$urandom, $urandom};
        req     = 1'b0;
        request = junk[$bits(mem_req_t)-1:0]; // don't care while req is low.
        @(negedge CLK);
        check_eq(32'(ack), 32'd0, "ack falls one edge after req falls");
    endtask

    task automatic exec_op(input mem_op_t op, input byte_addr_t addr, input word_t wdata,
                           input int hold);
        mem_req_t rq;
        mem_rsp_t rsp;
        word_t    exp_rdata;
        logic     exp_err;
        int       exp_lat;
        int       lat;
        string    tag;
        tag = $sformatf("%s at %h", op.name(), addr);
        model_apply(op, addr, wdata, exp_rdata, exp_err, exp_lat);
        rq.op    = op;
        rq.addr  = addr;
        rq.wdata = wdata;
        run_handshake(rq, hold, rsp, lat);
        check_eq(rsp.rdata, exp_rdata, {tag, " rdata"});
        check_eq(32'(rsp.err), 32'(exp_err), {tag, " err"});
        check_eq(lat, exp_lat, {tag, " req to ack cycles"});
    endtask

    initial begin
        mem_op_t     op;
        byte_addr_t  addr;
        byte_addr_t  win_base;
        logic [31:0] r;
        req         = 1'b0;
        request     = '0;
        arst_n      = 1'b0;
        err_count   = 0;
        check_count = 0;
        void'($urandom(42));

        repeat (RESET_CYCLES) begin
            @(negedge CLK);
            check_eq(32'(ack), 32'd0, "ack low during reset");
        end
        arst_n = 1'b1;
        @(negedge CLK);
        check_eq(32'(ack), 32'd0, "ack low after reset release");

        // word fill, then read everything back.
        for (int w = 0; w < WORDS; w++) begin
            exec_op(OP_SW, byte_addr_t'(w * 4), rand_word(), 0);
        end
        for (int w = 0; w < WORDS; w++) begin
            exec_op(OP_LW, byte_addr_t'(w * 4), '0, 0);
        end

        // small window so neighbouring bytes get read back often.
        r        = $urandom;
        win_base = {r[`LSU_ADDR_BITS-1:6], 6'd0};
        for (int i = 0; i < MIX_OPS; i++) begin
            r  = $urandom;
            op = mem_op_t'(r[2:0]);
            exec_op(op, aligned_addr(op, win_base), rand_word(), pick_hold());
        end

        for (int i = 0; i < MISALIGN_OPS; i++) begin
            op   = misaligned_op();
            addr = misaligned_addr(op);
            exec_op(op, addr, rand_word(), pick_hold());
            exec_op(OP_LW, {addr[`LSU_ADDR_BITS-1:2], 2'b00}, '0, pick_hold());
        end

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out after %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, err_count);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
lsu_pkg.sv
lsu_decode.sv
byte_mem_engine.sv
lsu_response.sv
lsu_top.sv
tb_clock.sv
tb_lsu.sv

/* run.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lsu -f src.f -o tb_lsu_sim

out=$(./obj_dir/tb_lsu_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
